/* aes_256.f */
+incdir+sim
rtl/aes_cfg_pkg.sv
rtl/aes_math_pkg.sv
rtl/aes_ctrl.sv
rtl/aes_key_expand.sv
rtl/aes_round.sv
rtl/aes_256_top.sv
sim/tb_aes_256.sv

/* Bender.yml */
package:
  name: aes_256

sources:
  - files:
      - rtl/aes_cfg_pkg.sv
      - rtl/aes_math_pkg.sv
      - rtl/aes_ctrl.sv
      - rtl/aes_key_expand.sv
      - rtl/aes_round.sv
      - rtl/aes_256_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_aes_256.sv

/* sim/aes_ref_model.svh */
// ----------------------------------------------------------------------
// AES-256 reference model
// Byte-oriented encryption with its own key schedule, used by the
// testbench to derive expected ciphertext
// ----------------------------------------------------------------------

`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// Multiply by 2 in GF(2^8)
function automatic logic [7:0] gf_mul2(input logic [7:0] b);
    logic [7:0] sh;
    sh = b << 1;
    return b[7] ? (sh ^ 8'h1b) : sh;
endfunction

function automatic logic [127:0] expected_cipher(input logic [127:0] pt,
                                                 input logic [255:0] key);
    logic [31:0]  w [60];
    logic [31:0]  t;
    logic [7:0]   s [16];
    logic [7:0]   u [16];
    logic [7:0]   a0, a1, a2, a3;
    logic [7:0]   rc;
    logic [127:0] ct;
    int           row;
    int           col;

    // Key schedule, Nk = 8, 60 words
    rc = 8'h01;
    for (int i = 0; i < 8; i++) begin
        w[i] = key[255-32*i -: 32];
    end
    for (int i = 8; i < 60; i++) begin
        t = w[i-1];
        if (i % 8 == 0) begin
            t = {t[23:0], t[31:24]};
            for (int b = 0; b < 4; b++) begin
                t[8*b +: 8] = aes_math_pkg::SBOX[t[8*b +: 8]];
            end
            t[31:24] = t[31:24] ^ rc;
            rc = gf_mul2(rc);
        end else if (i % 8 == 4) begin
            for (int b = 0; b < 4; b++) begin
                t[8*b +: 8] = aes_math_pkg::SBOX[t[8*b +: 8]];
            end
        end
        w[i] = w[i-8] ^ t;
    end

    // Byte i sits in row i%4 of column i/4
    for (int i = 0; i < 16; i++) begin
        s[i] = pt[127-8*i -: 8] ^ w[i/4][31-8*(i%4) -: 8];
    end

    for (int r = 1; r <= 14; r++) begin
        // SubBytes and ShiftRows in one pass
        for (int i = 0; i < 16; i++) begin
            row  = i % 4;
            col  = i / 4;
            u[i] = aes_math_pkg::SBOX[s[row + 4*((col + row) % 4)]];
        end
        if (r < 14) begin
            for (int c = 0; c < 4; c++) begin
                a0 = u[4*c];
                a1 = u[4*c+1];
                a2 = u[4*c+2];
                a3 = u[4*c+3];
                s[4*c]   = gf_mul2(a0) ^ gf_mul2(a1) ^ a1 ^ a2 ^ a3;
                s[4*c+1] = a0 ^ gf_mul2(a1) ^ gf_mul2(a2) ^ a2 ^ a3;
                s[4*c+2] = a0 ^ a1 ^ gf_mul2(a2) ^ gf_mul2(a3) ^ a3;
                s[4*c+3] = gf_mul2(a0) ^ a0 ^ a1 ^ a2 ^ gf_mul2(a3);
            end
        end else begin
            s = u;
        end
        for (int i = 0; i < 16; i++) begin
            s[i] = s[i] ^ w[4*r + i/4][31-8*(i%4) -: 8];
        end
    end

    for (int i = 0; i < 16; i++) begin
        ct[127-8*i -: 8] = s[i];
    end
    return ct;
endfunction

`endif

/* sim/tb_aes_256.sv */
// ----------------------------------------------------------------------
// AES-256 core testbench
// Known-answer vector, random jobs with idle gaps, ignored starts
// while busy and back-to-back jobs, all checked against a model
// ----------------------------------------------------------------------

module tb_aes_256;

    localparam int KEY_WORDS = 8;
    localparam int LATENCY   = 67;
    localparam int TIMEOUT   = 200;

    localparam logic [255:0] FIPS_KEY =
        256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
    localparam aes_cfg_pkg::block_t FIPS_PT = 128'h00112233445566778899aabbccddeeff;
    localparam aes_cfg_pkg::block_t FIPS_CT = 128'h8ea2b7ca516745bfeafc49904b496089;

    logic                    clk;
    logic                    rst;
    logic                    start;
    aes_cfg_pkg::block_t     block_in;
    logic [32*KEY_WORDS-1:0] key_in;
    aes_cfg_pkg::block_t     block_out;
    logic                    data_valid;
    logic                    busy;

    int                  errors;
    int                  tests_run;
    int                  tests_ok;
    bit                  timed_out;
    logic [31:0]         rng_state;
    aes_cfg_pkg::block_t last_out;

    `include "aes_ref_model.svh"

    aes_256_top #(
        .KEY_WORDS(KEY_WORDS)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .block_in  (block_in),
        .key_in    (key_in),
        .block_out (block_out),
        .data_valid(data_valid),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Random numbers and checks
    // ------------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic aes_cfg_pkg::block_t rand_block();
        return {next_rand(), next_rand(), next_rand(), next_rand()};
    endfunction

    function automatic logic [255:0] rand_key();
        return {rand_block(), rand_block()};
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("ERR %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            $display("%s: FAIL with %0d errors", name, errors - err_before);
        end
    endtask

    // ------------------------------------------------------------------
    // One job, optionally with a stray start at busy cycle glitch_at
    // ------------------------------------------------------------------
    task automatic run_job(input aes_cfg_pkg::block_t pt, input logic [255:0] key,
                           input int glitch_at);
        aes_cfg_pkg::block_t exp;
        int                  cnt;
        bit                  seen;
        exp  = expected_cipher(pt, key);
        seen = 1'b0;
        @(posedge clk);
        start    <= 1'b1;
        block_in <= pt;
        key_in   <= key;
        // Previous result still held, no valid pulse
        @(negedge clk);
        check_bit("data_valid", data_valid, 1'b0);
        check_value("block_out", block_out, last_out);
        @(posedge clk);
        start <= 1'b0;
        cnt = 0;
        while (cnt < TIMEOUT) begin
            @(negedge clk);
            if (data_valid) begin
                seen = 1'b1;
                break;
            end
            check_bit("busy", busy, 1'b1);
            cnt++;
            @(posedge clk);
            if (cnt == glitch_at) begin
                start    <= 1'b1;
                block_in <= rand_block();
                key_in   <= rand_key();
            end else begin
                start <= 1'b0;
            end
        end
        if (!seen) begin
            $display("timeout: data_valid did not rise within %0d cycles", TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end else begin
            assert (cnt == LATENCY) else begin
                $display("data_valid rose %0d edges after start instead of %0d",
                         cnt, LATENCY);
                errors++;
            end
            check_bit("busy", busy, 1'b0);
            check_value("block_out", block_out, exp);
        end
        last_out = exp;
    endtask

    // Idle cycles with noise on the data inputs, result must hold
    task automatic idle_gap(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            start    <= 1'b0;
            block_in <= rand_block();
            @(negedge clk);
            check_bit("data_valid", data_valid, 1'b0);
            check_bit("busy", busy, 1'b0);
            check_value("block_out", block_out, last_out);
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        aes_cfg_pkg::block_t pt;
        logic [255:0]        key;
        int                  err0;
        start     = 1'b0;
        block_in  = '0;
        key_in    = '0;
        rst       = 1'b1;
        errors    = 0;
        tests_run = 0;
        tests_ok  = 0;
        timed_out = 1'b0;
        last_out  = '0;
        rng_state = 32'h7f268650;

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        err0 = errors;
        @(negedge clk);
        check_bit("busy", busy, 1'b0);
        check_bit("data_valid", data_valid, 1'b0);
        check_value("block_out", block_out, '0);
        report_test("reset state", err0);

        if (!timed_out) begin
            err0 = errors;
            run_job(FIPS_PT, FIPS_KEY, 0);
            check_value("block_out", block_out, FIPS_CT);
            idle_gap(3);
            report_test("fips-197 vector", err0);
        end

        if (!timed_out) begin
            err0 = errors;
            for (int i = 0; i < 40 && !timed_out; i++) begin
                pt  = rand_block();
                key = rand_key();
                run_job(pt, key, 0);
                idle_gap(1 + next_rand() % 8);
            end
            report_test("random jobs with idle gaps", err0);
        end

        if (!timed_out) begin
            err0 = errors;
            for (int i = 0; i < 5 && !timed_out; i++) begin
                pt  = rand_block();
                key = rand_key();
                run_job(pt, key, 1 + next_rand() % 60);
                idle_gap(2);
            end
            report_test("start ignored while busy", err0);
        end

        if (!timed_out) begin
            err0 = errors;
            for (int i = 0; i < 8 && !timed_out; i++) begin
                pt  = rand_block();
                key = rand_key();
                run_job(pt, key, 0);
            end
            if (!timed_out) begin
                idle_gap(2);
            end
            report_test("back-to-back jobs", err0);
        end

        $display("summary: %0d of %0d tests ok, %0d errors", tests_ok, tests_run, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* rtl/aes_256_top.sv */
// ----------------------------------------------------------------------
// AES encryption core, iterative
// Start/busy/data_valid handshake around the sequencer, key schedule
// and round datapath; key length chosen by KEY_WORDS
// ----------------------------------------------------------------------

module aes_256_top #(
    parameter int KEY_WORDS = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  aes_cfg_pkg::block_t     block_in,
    input  logic [32*KEY_WORDS-1:0] key_in,
    output aes_cfg_pkg::block_t     block_out,
    output logic                    data_valid,
    output logic                    busy
);

    logic                   key_load;
    logic                   key_step;
    logic                   expand_done;
    aes_cfg_pkg::round_op_t round_op;
    aes_cfg_pkg::round_t    round_idx;
    aes_cfg_pkg::block_t    round_key;

    aes_ctrl #(
        .KEY_WORDS(KEY_WORDS)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .expand_done(expand_done),
        .key_load   (key_load),
        .key_step   (key_step),
        .round_op   (round_op),
        .round_idx  (round_idx),
        .busy       (busy),
        .data_valid (data_valid)
    );

    aes_key_expand #(
        .KEY_WORDS(KEY_WORDS)
    ) u_key_expand (
        .clk        (clk),
        .rst        (rst),
        .key_load   (key_load),
        .key_in     (key_in),
        .key_step   (key_step),
        .round_idx  (round_idx),
        .expand_done(expand_done),
        .round_key  (round_key)
    );

    aes_round u_round (
        .clk      (clk),
        .rst      (rst),
        .round_op (round_op),
        .block_in (block_in),
        .round_key(round_key),
        .state_out(block_out)
    );

endmodule

/* rtl/aes_round.sv */
// ----------------------------------------------------------------------
// AES round datapath
// Cipher state register with one full or final encryption round,
// or a plain key add, applied per cycle
// ----------------------------------------------------------------------

module aes_round (
    input  logic                   clk,
    input  logic                   rst,
    input  aes_cfg_pkg::round_op_t round_op,
    input  aes_cfg_pkg::block_t    block_in,
    input  aes_cfg_pkg::block_t    round_key,
    output aes_cfg_pkg::block_t    state_out
);

    aes_cfg_pkg::block_t state;
    aes_cfg_pkg::block_t shifted;
    aes_cfg_pkg::block_t state_next;

    // SubBytes then ShiftRows, shared by middle and final rounds
    assign shifted = aes_math_pkg::shift_rows(aes_math_pkg::sub_bytes(state));

    always_comb begin
        case (round_op)
            aes_cfg_pkg::OP_LOAD: state_next = block_in;
            aes_cfg_pkg::OP_INIT: state_next = state ^ round_key;
            aes_cfg_pkg::OP_MID:  state_next = aes_math_pkg::mix_columns(shifted) ^ round_key;
            aes_cfg_pkg::OP_LAST: state_next = shifted ^ round_key;
            default:              state_next = state;
        endcase
    end

    // Cleared so the output reads zero after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= '0;
        end else begin
            state <= state_next;
        end
    end

    assign state_out = state;

    assert property (@(posedge clk) disable iff (rst)
        round_op inside {aes_cfg_pkg::OP_HOLD, aes_cfg_pkg::OP_LOAD, aes_cfg_pkg::OP_INIT,
                         aes_cfg_pkg::OP_MID, aes_cfg_pkg::OP_LAST})
        else $error("round_op out of range: %0h", round_op);

endmodule

/* rtl/aes_key_expand.sv */
// ----------------------------------------------------------------------
// AES key schedule
// Stores the cipher key, expands it one word per step and presents
// the round key selected by the round index
// ----------------------------------------------------------------------

module aes_key_expand #(
    parameter int KEY_WORDS = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    key_load,
    input  logic [32*KEY_WORDS-1:0] key_in,
    input  logic                    key_step,
    input  aes_cfg_pkg::round_t     round_idx,
    output logic                    expand_done,
    output aes_cfg_pkg::block_t     round_key
);

    // 4*(Nr+1) words for this key length
    localparam int TOTAL_WORDS = aes_cfg_pkg::BLOCK_WORDS * (KEY_WORDS + 7);
    localparam int SCHED_DEPTH = aes_cfg_pkg::BLOCK_WORDS * (aes_cfg_pkg::MAX_KEY_WORDS + 7);

    aes_cfg_pkg::word_t     sched [SCHED_DEPTH];
    aes_cfg_pkg::word_idx_t word_idx;
    aes_cfg_pkg::word_idx_t key_base;
    logic [2:0]             key_pos;
    logic [3:0]             rcon_idx;
    aes_cfg_pkg::word_t     prev_word;
    aes_cfg_pkg::word_t     temp_word;
    aes_cfg_pkg::word_t     new_word;

    // ------------------------------------------------------------------
    // Next schedule word from w[i-1] and w[i-Nk]
    // ------------------------------------------------------------------
    always_comb begin
        prev_word = sched[word_idx - 6'd1];
        if (key_pos == 3'd0) begin
            temp_word = aes_math_pkg::sub_word(aes_math_pkg::rot_word(prev_word))
                      ^ {aes_math_pkg::RCON[rcon_idx], 24'h0};
        end else if (KEY_WORDS > 6 && key_pos == 3'd4) begin
            temp_word = aes_math_pkg::sub_word(prev_word);
        end else begin
            temp_word = prev_word;
        end
        new_word = sched[word_idx - aes_cfg_pkg::word_idx_t'(KEY_WORDS)] ^ temp_word;
    end

    always_ff @(posedge clk) begin
        if (key_load) begin
            for (int i = 0; i < KEY_WORDS; i++) begin
                sched[i] <= key_in[32*(KEY_WORDS-1-i) +: 32];
            end
        end else if (key_step) begin
            sched[word_idx] <= new_word;
        end
    end

    // Index parks at the end so an idle schedule reads as complete
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            word_idx <= aes_cfg_pkg::word_idx_t'(TOTAL_WORDS);
            key_pos  <= '0;
            rcon_idx <= '0;
        end else if (key_load) begin
            word_idx <= aes_cfg_pkg::word_idx_t'(KEY_WORDS);
            key_pos  <= '0;
            rcon_idx <= '0;
        end else if (key_step) begin
            word_idx <= word_idx + 6'd1;
            key_pos  <= (key_pos == 3'(KEY_WORDS - 1)) ? 3'd0 : key_pos + 3'd1;
            if (key_pos == 3'd0) begin
                rcon_idx <= rcon_idx + 4'd1;
            end
        end
    end

    assign expand_done = key_step && (word_idx == aes_cfg_pkg::word_idx_t'(TOTAL_WORDS - 1));

    // Round key r is words 4r..4r+3
    assign key_base  = {round_idx, 2'b00};
    assign round_key = {sched[key_base], sched[key_base + 6'd1],
                        sched[key_base + 6'd2], sched[key_base + 6'd3]};

    assert property (@(posedge clk) disable iff (rst) key_step |-> word_idx < TOTAL_WORDS)
        else $error("key_step after schedule complete");

endmodule

/* rtl/aes_ctrl.sv */
// ----------------------------------------------------------------------
// AES sequencer
// Accepts a start pulse, runs key expansion, then steps the datapath
// through the initial key add, the full rounds and the final round
// ----------------------------------------------------------------------

module aes_ctrl #(
    parameter int KEY_WORDS = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   expand_done,
    output logic                   key_load,
    output logic                   key_step,
    output aes_cfg_pkg::round_op_t round_op,
    output aes_cfg_pkg::round_t    round_idx,
    output logic                   busy,
    output logic                   data_valid
);

    // Nr = Nk + 6
    localparam aes_cfg_pkg::round_t LAST_ROUND = aes_cfg_pkg::round_t'(KEY_WORDS + 6);

    typedef enum logic [2:0] {
        IDLE,
        EXPAND,
        INIT,
        ROUNDS,
        FINAL,
        DONE
    } ctrl_state_t;

    ctrl_state_t         state;
    ctrl_state_t         state_next;
    aes_cfg_pkg::round_t round_next;

    // ------------------------------------------------------------------
    // Next state and round counter
    // ------------------------------------------------------------------
    always_comb begin
        state_next = state;
        round_next = round_idx;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = EXPAND;
                end
            end
            EXPAND: begin
                if (expand_done) begin
                    state_next = INIT;
                end
            end
            INIT: begin
                state_next = ROUNDS;
                round_next = 4'd1;
            end
            ROUNDS: begin
                round_next = round_idx + 4'd1;
                // Counter reaching Nr-1 hands over to the final round
                if (round_idx == LAST_ROUND - 4'd1) begin
                    state_next = FINAL;
                end
            end
            FINAL: begin
                state_next = DONE;
            end
            default: begin
                state_next = IDLE;
                round_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            round_idx <= '0;
        end else begin
            state     <= state_next;
            round_idx <= round_next;
        end
    end

    // ------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------
    always_comb begin
        case (state)
            IDLE:    round_op = start ? aes_cfg_pkg::OP_LOAD : aes_cfg_pkg::OP_HOLD;
            INIT:    round_op = aes_cfg_pkg::OP_INIT;
            ROUNDS:  round_op = aes_cfg_pkg::OP_MID;
            FINAL:   round_op = aes_cfg_pkg::OP_LAST;
            default: round_op = aes_cfg_pkg::OP_HOLD;
        endcase
    end

    // Start only counts in IDLE, so busy and DONE both block it
    assign key_load   = (state == IDLE) && start;
    assign key_step   = (state == EXPAND);
    assign busy       = state inside {EXPAND, INIT, ROUNDS, FINAL};
    assign data_valid = (state == DONE);

    assert property (@(posedge clk) disable iff (rst) expand_done |-> (state == EXPAND))
        else $error("expand_done outside key expansion");

endmodule

/* rtl/aes_math_pkg.sv */
// ----------------------------------------------------------------------
// AES cipher arithmetic
// Forward S-box, round constants and the byte, word and block
// transforms used by the key schedule and the round datapath
// ----------------------------------------------------------------------

package aes_math_pkg;

    // Forward S-box, row-major by input byte
    localparam aes_cfg_pkg::byte_t SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5, 8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe,
    8'hd7, 8'hab, 8'h76, 8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0, 8'had, 8'hd4,
    8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0, 8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7,
    8'hcc, 8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15, 8'h04, 8'hc7, 8'h23, 8'hc3,
    8'h18, 8'h96, 8'h05, 8'h9a, 8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75, 8'h09,
    8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0, 8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3,
    8'h2f, 8'h84, 8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b, 8'h6a, 8'hcb, 8'hbe,
    8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf, 8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8, 8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92,
    8'h9d, 8'h38, 8'hf5, 8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2, 8'hcd, 8'h0c,
    8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17, 8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19,
    8'h73, 8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88, 8'h46, 8'hee, 8'hb8, 8'h14,
    8'hde, 8'h5e, 8'h0b, 8'hdb, 8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c, 8'hc2,
    8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79, 8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5,
    8'h4e, 8'ha9, 8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08, 8'hba, 8'h78, 8'h25,
    8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6, 8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e, 8'h61, 8'h35, 8'h57, 8'hb9, 8'h86,
    8'hc1, 8'h1d, 8'h9e, 8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94, 8'h9b, 8'h1e,
    8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf, 8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42,
    8'h68, 8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // Round constants, first byte of the rcon word
    localparam aes_cfg_pkg::byte_t RCON [10] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    function automatic aes_cfg_pkg::byte_t sbox(input aes_cfg_pkg::byte_t b);
        return SBOX[b];
    endfunction

    // Multiply by x in GF(2^8)
    function automatic aes_cfg_pkg::byte_t xtime(input aes_cfg_pkg::byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic aes_cfg_pkg::word_t rot_word(input aes_cfg_pkg::word_t w);
        return {w[23:0], w[31:24]};
    endfunction

    function automatic aes_cfg_pkg::word_t sub_word(input aes_cfg_pkg::word_t w);
        return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
    endfunction

    function automatic aes_cfg_pkg::block_t sub_bytes(input aes_cfg_pkg::block_t s);
        aes_cfg_pkg::block_t r;
        for (int c = 0; c < aes_cfg_pkg::BLOCK_WORDS; c++) begin
            r[32*c +: 32] = sub_word(s[32*c +: 32]);
        end
        return r;
    endfunction

    // Column c is s[127-32c -: 32], row r is byte r of that column
    function automatic aes_cfg_pkg::block_t shift_rows(input aes_cfg_pkg::block_t s);
        aes_cfg_pkg::block_t r;
        for (int c = 0; c < aes_cfg_pkg::BLOCK_WORDS; c++) begin
            for (int row = 0; row < 4; row++) begin
                r[127-32*c-8*row -: 8] = s[127-32*((c+row)%4)-8*row -: 8];
            end
        end
        return r;
    endfunction

    // b_i = a_i ^ (a0^a1^a2^a3) ^ xtime(a_i ^ a_i+1)
    function automatic aes_cfg_pkg::block_t mix_columns(input aes_cfg_pkg::block_t s);
        aes_cfg_pkg::block_t r;
        aes_cfg_pkg::byte_t  a [4];
        aes_cfg_pkg::byte_t  t;
        for (int c = 0; c < aes_cfg_pkg::BLOCK_WORDS; c++) begin
            for (int i = 0; i < 4; i++) begin
                a[i] = s[127-32*c-8*i -: 8];
            end
            t = a[0] ^ a[1] ^ a[2] ^ a[3];
            for (int i = 0; i < 4; i++) begin
                r[127-32*c-8*i -: 8] = a[i] ^ t ^ xtime(a[i] ^ a[(i+1)%4]);
            end
        end
        return r;
    endfunction

endpackage

/* rtl/aes_cfg_pkg.sv */
// ----------------------------------------------------------------------
// AES core configuration
// Widths, counts and shared types of the iterative AES encryption core,
// plus the per-cycle round operation passed from control to datapath
// ----------------------------------------------------------------------

package aes_cfg_pkg;

    // Block and word geometry
    localparam int BLOCK_BITS    = 128;
    localparam int WORD_BITS     = 32;
    localparam int BLOCK_WORDS   = BLOCK_BITS / WORD_BITS;

    // AES-256 is the widest key, it sizes storage and counters
    localparam int MAX_KEY_WORDS = 8;

    typedef logic [7:0]            byte_t;
    typedef logic [WORD_BITS-1:0]  word_t;
    typedef logic [BLOCK_BITS-1:0] block_t;

    // Round key index 0..Nr, at most 14
    typedef logic [3:0]            round_t;

    // Index into the expanded key schedule, at most 60 words
    typedef logic [5:0]            word_idx_t;

    // Operation applied to the cipher state on the next edge
    typedef enum logic [2:0] {
        OP_HOLD,
        OP_LOAD,
        OP_INIT,
        OP_MID,
        OP_LAST
    } round_op_t;

endpackage
